//--- div_array.f
div_pkg.sv
div_lane_dpath.sv
div_lane.sv
div_dispatch.sv
div_collect.sv
div_array.sv
div_array_tb.sv

//--- div_array.sv
//----------------------------------------------------------
// multi-lane divide engine top level
// dispatcher, array of divider lanes, collector
//----------------------------------------------------------

`timescale 1ns/10ps

module div_array #(
  parameter int NUM_LANES = 4
) (
  input  logic              clk,
  input  logic              reset,
  input  logic              req_val,
  output logic              req_rdy,
  input  div_pkg::fn_t      req_fn,
  input  div_pkg::operand_t req_a,
  input  div_pkg::operand_t req_b,
  output logic              resp_val,
  input  logic              resp_rdy,
  output div_pkg::result_t  resp_result
);

  import div_pkg::*;

  // per-lane handshake wires
  logic [NUM_LANES-1:0]    lane_req_val;
  logic [NUM_LANES-1:0]    lane_req_rdy;
  logic [NUM_LANES-1:0]    lane_resp_val;
  logic [NUM_LANES-1:0]    lane_resp_rdy;
  result_t [NUM_LANES-1:0] lane_resp_result;

  div_dispatch #(
    .NUM_LANES (NUM_LANES)
  ) u_dispatch (
    .clk          (clk),
    .reset        (reset),
    .req_val      (req_val),
    .req_rdy      (req_rdy),
    .lane_req_val (lane_req_val),
    .lane_req_rdy (lane_req_rdy)
  );

  // operands and function fan out to every lane
  for (genvar i = 0; i < NUM_LANES; i++) begin : g_lane
    div_lane u_lane (
      .clk         (clk),
      .reset       (reset),
      .req_val     (lane_req_val[i]),
      .req_rdy     (lane_req_rdy[i]),
      .req_fn      (req_fn),
      .req_a       (req_a),
      .req_b       (req_b),
      .resp_val    (lane_resp_val[i]),
      .resp_rdy    (lane_resp_rdy[i]),
      .resp_result (lane_resp_result[i])
    );
  end

  div_collect #(
    .NUM_LANES (NUM_LANES)
  ) u_collect (
    .clk              (clk),
    .reset            (reset),
    .lane_resp_val    (lane_resp_val),
    .lane_resp_result (lane_resp_result),
    .lane_resp_rdy    (lane_resp_rdy),
    .resp_val         (resp_val),
    .resp_rdy         (resp_rdy),
    .resp_result      (resp_result)
  );

endmodule

//--- div_array_tb.sv
//----------------------------------------------------------
// testbench for the multi-lane divide engine
// stimulus table, random back-pressure, watchdog
//----------------------------------------------------------

`timescale 1ns/10ps

module div_array_tb;

  import div_pkg::*;

  localparam int NUM_LANES   = 4;
  localparam int NUM_ENTRIES = 13;
  // shortest gap from a request transfer to its response transfer
  localparam int MIN_LATENCY = 33;
  localparam int TIMEOUT_CYC = NUM_ENTRIES * 40 + 200;

  logic     clk;
  logic     reset;
  logic     req_val;
  logic     req_rdy;
  fn_t      req_fn;
  operand_t req_a;
  operand_t req_b;
  logic     resp_val;
  logic     resp_rdy;
  result_t  resp_result;

  // stimulus table, expected value is {remainder, quotient}
  fn_t      tab_fn  [NUM_ENTRIES];
  operand_t tab_a   [NUM_ENTRIES];
  operand_t tab_b   [NUM_ENTRIES];
  result_t  tab_exp [NUM_ENTRIES];
  int       n_entries;

  // edge count, used to measure request to response latency
  int unsigned cycle_count = 0;
  int unsigned issue_cycle [NUM_ENTRIES];
  int          tx_count;
  int          rx_count;
  integer      seed;

  div_array #(
    .NUM_LANES (NUM_LANES)
  ) u_div_array (
    .clk         (clk),
    .reset       (reset),
    .req_val     (req_val),
    .req_rdy     (req_rdy),
    .req_fn      (req_fn),
    .req_a       (req_a),
    .req_b       (req_b),
    .resp_val    (resp_val),
    .resp_rdy    (resp_rdy),
    .resp_result (resp_result)
  );

  // 20 ns clock
  always #10 clk = ~clk;

  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
  end

  //----------------------------------------------------------
  // error reporting
  //----------------------------------------------------------

  task automatic report_error(input string msg);
    $display("%s", msg);
    $display("Simulation finished: FAIL");
    $fatal(1, "stopped at first error");
  endtask

  task automatic report_mismatch(input string name, input logic [63:0] exp_val,
                                 input logic [63:0] act_val);
    report_error($sformatf("MISMATCH time=%0t signal=%s expected=%h actual=%h",
                           $time, name, exp_val, act_val));
  endtask

  //----------------------------------------------------------
  // stimulus table
  //----------------------------------------------------------

  task automatic add_entry(input fn_t fn, input operand_t a, input operand_t b,
                           input operand_t rem, input operand_t quot);
    tab_fn[n_entries]  = fn;
    tab_a[n_entries]   = a;
    tab_b[n_entries]   = b;
    tab_exp[n_entries] = {rem, quot};
    n_entries++;
  endtask

  task automatic load_table();
    n_entries = 0;
    // plain unsigned cases
    add_entry(FN_UNSIGNED, 32'd100, 32'd7, 32'd2, 32'd14);
    // dividend below divisor, quotient zero
    add_entry(FN_UNSIGNED, 32'd5, 32'd9, 32'd5, 32'd0);
    // divisor of one
    add_entry(FN_UNSIGNED, 32'd12345, 32'd1, 32'd0, 32'd12345);
    add_entry(FN_UNSIGNED, 32'hdeadbeef, 32'h10, 32'hf, 32'h0deadbee);
    // top bit set but the operands stay unsigned
    add_entry(FN_UNSIGNED, 32'hffffffff, 32'd2, 32'd1, 32'h7fffffff);
    add_entry(FN_UNSIGNED, 32'h80000000, 32'd3, 32'd2, 32'h2aaaaaaa);
    add_entry(FN_UNSIGNED, 32'hfffffff9, 32'd2, 32'd1, 32'h7ffffffc);
    // signed 7 / 2 in all four sign combinations
    // truncation toward zero, remainder takes the dividend sign
    add_entry(FN_SIGNED, 32'd7, 32'd2, 32'd1, 32'd3);
    add_entry(FN_SIGNED, 32'hfffffff9, 32'd2, 32'hffffffff, 32'hfffffffd);
    add_entry(FN_SIGNED, 32'd7, 32'hfffffffe, 32'd1, 32'hfffffffd);
    add_entry(FN_SIGNED, 32'hfffffff9, 32'hfffffffe, 32'hffffffff, 32'd3);
    // -100 / 7
    add_entry(FN_SIGNED, 32'hffffff9c, 32'd7, 32'hfffffffe, 32'hfffffff2);
    // overflow, most negative over minus one
    add_entry(FN_SIGNED, 32'h80000000, 32'hffffffff, 32'd0, 32'h80000000);
  endtask

  //----------------------------------------------------------
  // request and response sides
  //----------------------------------------------------------

  task automatic drive_requests();
    int i;
    for (i = 0; i < NUM_ENTRIES; i++) begin
      @(posedge clk);
      #1;
      req_val = 1'b1;
      req_fn  = tab_fn[i];
      req_a   = tab_a[i];
      req_b   = tab_b[i];
      // hold until the pointed lane is ready, transfer on the next edge
      @(negedge clk);
      while (!req_rdy) begin
        @(negedge clk);
      end
      issue_cycle[i] = cycle_count + 1;
      tx_count       = i + 1;
    end
    @(posedge clk);
    #1;
    req_val = 1'b0;
  endtask

  task automatic collect_responses();
    logic [31:0] rand_word;
    int unsigned latency;
    while (rx_count < NUM_ENTRIES) begin
      @(posedge clk);
      #1;
      // random back-pressure, about half the cycles
      rand_word = $random(seed);
      resp_rdy  = rand_word[0];
      @(negedge clk);
      if (resp_val && resp_rdy) begin
        assert (rx_count < tx_count)
          else report_error("response arrived with no request outstanding");
        latency = cycle_count + 1 - issue_cycle[rx_count];
        assert (resp_result === tab_exp[rx_count])
          else report_mismatch("resp_result", tab_exp[rx_count], resp_result);
        assert (latency >= MIN_LATENCY)
          else report_error($sformatf("response %0d came back after only %0d cycles",
                                      rx_count, latency));
        rx_count++;
      end
    end
  endtask

  //----------------------------------------------------------
  // main sequence
  //----------------------------------------------------------

  initial begin
    clk      = 1'b0;
    reset    = 1'b1;
    req_val  = 1'b0;
    req_fn   = FN_UNSIGNED;
    req_a    = '0;
    req_b    = '0;
    resp_rdy = 1'b0;
    tx_count = 0;
    rx_count = 0;
    seed     = 32'ha2bc;
    load_table();
    assert (n_entries == NUM_ENTRIES)
      else report_error("stimulus table size does not match its declared length");
    repeat (2) @(posedge clk);
    #1;
    reset = 1'b0;
    // every lane idle after reset
    @(negedge clk);
    assert (req_rdy === 1'b1)
      else report_mismatch("req_rdy", 64'd1, {63'd0, req_rdy});
    assert (resp_val === 1'b0)
      else report_mismatch("resp_val", 64'd0, {63'd0, resp_val});
    fork
      drive_requests();
      collect_responses();
    join
    // no further response once every entry has been matched
    repeat (40) begin
      @(negedge clk);
      assert (resp_val === 1'b0)
        else report_error("extra response after the last table entry");
    end
    $display("Simulation finished: PASS");
    $finish;
  end

  // watchdog
  initial begin
    repeat (TIMEOUT_CYC) @(posedge clk);
    report_error($sformatf("timeout after %0d cycles, %0d of %0d responses received",
                           TIMEOUT_CYC, rx_count, NUM_ENTRIES));
  end

endmodule

//--- div_collect.sv
//----------------------------------------------------------
// round-robin response collector, keeps request order
//----------------------------------------------------------

`timescale 1ns/10ps

module div_collect #(
  parameter int NUM_LANES = 4
) (
  input  logic                                clk,
  input  logic                                reset,
  input  logic             [NUM_LANES-1:0]    lane_resp_val,
  input  div_pkg::result_t [NUM_LANES-1:0]    lane_resp_result,
  output logic             [NUM_LANES-1:0]    lane_resp_rdy,
  output logic                                resp_val,
  input  logic                                resp_rdy,
  output div_pkg::result_t                    resp_result
);

  localparam int PTR_W = (NUM_LANES > 1) ? $clog2(NUM_LANES) : 1;

  logic [PTR_W-1:0] ptr;

  // same stepping as the dispatcher, so lanes drain in issue order
  always_ff @(posedge clk) begin
    if (reset) begin
      ptr <= '0;
    end else if (resp_val && resp_rdy) begin
      if (ptr == PTR_W'(NUM_LANES - 1)) begin
        ptr <= '0;
      end else begin
        ptr <= ptr + 1'b1;
      end
    end
  end

  assign resp_val    = lane_resp_val[ptr];
  assign resp_result = lane_resp_result[ptr];

  // ready goes back to the pointed lane only
  always_comb begin
    lane_resp_rdy      = '0;
    lane_resp_rdy[ptr] = resp_rdy;
  end

  // a stalled response must stay put until it is taken
  a_resp_hold: assert property (@(posedge clk) disable iff (reset)
    (resp_val && !resp_rdy) |=> (resp_val && $stable(resp_result)));

endmodule

//--- div_dispatch.sv
//----------------------------------------------------------
// round-robin request dispatcher for the divider lanes
//----------------------------------------------------------

`timescale 1ns/10ps

module div_dispatch #(
  parameter int NUM_LANES = 4
) (
  input  logic                 clk,
  input  logic                 reset,
  input  logic                 req_val,
  output logic                 req_rdy,
  output logic [NUM_LANES-1:0] lane_req_val,
  input  logic [NUM_LANES-1:0] lane_req_rdy
);

  // at least one pointer bit, even for a single lane
  localparam int PTR_W = (NUM_LANES > 1) ? $clog2(NUM_LANES) : 1;

  logic [PTR_W-1:0] ptr;

  // pointer steps to the next lane on every accepted request
  always_ff @(posedge clk) begin
    if (reset) begin
      ptr <= '0;
    end else if (req_val && req_rdy) begin
      if (ptr == PTR_W'(NUM_LANES - 1)) begin
        ptr <= '0;
      end else begin
        ptr <= ptr + 1'b1;
      end
    end
  end

  // only the pointed lane sees the valid
  always_comb begin
    lane_req_val      = '0;
    lane_req_val[ptr] = req_val;
  end

  // stall while the pointed lane is still busy
  assign req_rdy = lane_req_rdy[ptr];

  a_one_lane: assert property (@(posedge clk) disable iff (reset)
    $onehot0(lane_req_val));

endmodule

//--- div_lane.sv
//----------------------------------------------------------
// one divider lane
// idle/calc/done control with val/rdy on both sides
//----------------------------------------------------------

`timescale 1ns/10ps

module div_lane (
  input  logic              clk,
  input  logic              reset,
  input  logic              req_val,
  output logic              req_rdy,
  input  div_pkg::fn_t      req_fn,
  input  div_pkg::operand_t req_a,
  input  div_pkg::operand_t req_b,
  output logic              resp_val,
  input  logic              resp_rdy,
  output div_pkg::result_t  resp_result
);

  typedef enum logic [1:0] {
    IDLE,
    CALC,
    DONE
  } lane_state_e;

  lane_state_e state;
  lane_state_e state_next;

  // datapath controls
  logic load;
  logic step;
  logic counter_is_zero;

  //----------------------------------------------------------
  // control FSM
  //----------------------------------------------------------

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= IDLE;
    end else begin
      state <= state_next;
    end
  end

  always_comb begin
    state_next = state;
    req_rdy    = 1'b0;
    resp_val   = 1'b0;
    load       = 1'b0;
    step       = 1'b0;
    case (state)
      IDLE: begin
        // operands load on the transfer edge
        req_rdy = 1'b1;
        load    = req_val;
        if (req_val) begin
          state_next = CALC;
        end
      end
      CALC: begin
        // one restoring step per cycle, last one at counter zero
        step = 1'b1;
        if (counter_is_zero) begin
          state_next = DONE;
        end
      end
      DONE: begin
        // hold the result until the consumer takes it
        resp_val = 1'b1;
        if (resp_rdy) begin
          state_next = IDLE;
        end
      end
      default: begin
        state_next = IDLE;
      end
    endcase
  end

  div_lane_dpath u_dpath (
    .clk             (clk),
    .reset           (reset),
    .fn              (req_fn),
    .a               (req_a),
    .b               (req_b),
    .load            (load),
    .step            (step),
    .counter_is_zero (counter_is_zero),
    .result          (resp_result)
  );

  //----------------------------------------------------------
  // checks
  //----------------------------------------------------------

  // divide by zero is not supported by this engine
  a_no_div_zero: assert property (@(posedge clk) disable iff (reset)
    (req_val && req_rdy) |-> (req_b != '0));

  // a lane never offers a result while taking a new request
  a_val_rdy_excl: assert property (@(posedge clk) disable iff (reset)
    !(resp_val && req_rdy));

endmodule

//--- div_lane_dpath.sv
//----------------------------------------------------------
// divider lane datapath
// operand unsigning, restoring shift-subtract, sign fix-up
//----------------------------------------------------------

`timescale 1ns/10ps

module div_lane_dpath (
  input  logic             clk,
  input  logic             reset,
  input  div_pkg::fn_t     fn,
  input  div_pkg::operand_t a,
  input  div_pkg::operand_t b,
  input  logic             load,
  input  logic             step,
  output logic             counter_is_zero,
  output div_pkg::result_t result
);

  import div_pkg::*;

  // remainder/quotient pair, one spare bit on top for the sign
  logic [RESULT_W:0] a_reg;
  // divisor aligned to the upper half
  logic [RESULT_W:0] b_reg;
  iter_t             counter;

  // request info needed again at the end for the fix-up
  fn_t  fn_reg;
  logic a_sign;
  logic b_sign;

  //----------------------------------------------------------
  // operand unsigning
  //----------------------------------------------------------

  operand_t a_mag;
  operand_t b_mag;
  operand_t a_norm;
  operand_t b_norm;

  // two's complement magnitude of each operand
  assign a_mag = a[OPERAND_W-1] ? (~a + 1'b1) : a;
  assign b_mag = b[OPERAND_W-1] ? (~b + 1'b1) : b;

  // unsigned requests go through untouched
  assign a_norm = (fn == FN_SIGNED) ? a_mag : a;
  assign b_norm = (fn == FN_SIGNED) ? b_mag : b;

  //----------------------------------------------------------
  // one restoring step
  //----------------------------------------------------------

  logic [RESULT_W:0] a_shift;
  logic [RESULT_W:0] diff;
  logic [RESULT_W:0] a_next;

  assign a_shift = a_reg << 1;
  assign diff    = a_shift - b_reg;

  // negative difference means the divisor did not fit, so restore
  // new quotient bit is the inverse of that sign
  assign a_next = diff[RESULT_W] ? {a_shift[RESULT_W:1], 1'b0}
                                 : {diff[RESULT_W:1], 1'b1};

  // payload registers, loaded on transfer and updated per step
  always_ff @(posedge clk) begin
    if (load) begin
      a_reg  <= {{(OPERAND_W + 1){1'b0}}, a_norm};
      b_reg  <= {1'b0, b_norm, {OPERAND_W{1'b0}}};
      fn_reg <= fn;
      a_sign <= a[OPERAND_W-1];
      b_sign <= b[OPERAND_W-1];
    end else if (step) begin
      a_reg <= a_next;
    end
  end

  // iteration counter
  always_ff @(posedge clk) begin
    if (reset) begin
      counter <= '0;
    end else if (load) begin
      counter <= ITER_LAST;
    end else if (step) begin
      counter <= counter - 1'b1;
    end
  end

  assign counter_is_zero = (counter == '0);

  //----------------------------------------------------------
  // sign fix-up
  //----------------------------------------------------------

  operand_t quot_mag;
  operand_t rem_mag;
  logic     quot_neg;
  logic     rem_neg;

  assign quot_mag = a_reg[OPERAND_W-1:0];
  assign rem_mag  = a_reg[RESULT_W-1:OPERAND_W];

  // quotient is negative when exactly one operand was negative
  assign quot_neg = (fn_reg == FN_SIGNED) && (a_sign ^ b_sign);
  // remainder follows the dividend
  assign rem_neg  = (fn_reg == FN_SIGNED) && a_sign;

  assign result[OPERAND_W-1:0]        = quot_neg ? (~quot_mag + 1'b1) : quot_mag;
  assign result[RESULT_W-1:OPERAND_W] = rem_neg ? (~rem_mag + 1'b1) : rem_mag;

endmodule

//--- div_pkg.sv
//----------------------------------------------------------
// shared types and constants for the divide engine
// operand, result, function code and iteration counter
//----------------------------------------------------------

package div_pkg;

  //----------------------------------------------------------
  // widths
  //----------------------------------------------------------

  // operands are fixed at 32 bits
  localparam int OPERAND_W = 32;
  // remainder in the upper half, quotient in the lower half
  localparam int RESULT_W  = 2 * OPERAND_W;
  // enough bits to count down one step per operand bit
  localparam int ITER_W    = 5;

  // dividend or divisor
  typedef logic [OPERAND_W-1:0] operand_t;
  // {remainder, quotient}
  typedef logic [RESULT_W-1:0]  result_t;
  // divide function select
  typedef logic                 fn_t;
  // restoring step counter
  typedef logic [ITER_W-1:0]    iter_t;

  //----------------------------------------------------------
  // function codes
  //----------------------------------------------------------

  localparam fn_t FN_UNSIGNED = 1'b0;
  localparam fn_t FN_SIGNED   = 1'b1;

  // counter start value, counts down to zero over 32 steps
  localparam iter_t ITER_LAST = iter_t'(OPERAND_W - 1);

endpackage

//--- run_sim.sh
#!/bin/sh
# build the divide engine testbench with Verilator and run it
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal --top-module div_array_tb \
  -f div_array.f -o div_array_sim || { echo "build failed"; exit 1; }
./obj_dir/div_array_sim > sim.log 2>&1 || echo "simulator exited with an error" >> sim.log
cat sim.log
grep -q "Simulation finished: FAIL" sim.log && { echo "result: failed"; exit 1; }
grep -q "Simulation finished: PASS" sim.log || { echo "result: no pass line"; exit 1; }
echo "result: passed"
